// File: hw/rs_pkg.sv
/*
 * Shared definitions for the reservation station
 *   Sizes of the station, register file and ROB
 *   Width typedefs for operands, tags, indices and entry masks
 *   Functional-unit class codes and occupancy levels
 *   ALU function and opcode-group constants
 *   Lowest-set-bit helper for the priority pickers
 */
package rs_pkg;

	// Structure sizes
	localparam int RS_SIZE      = 8;           // Entries in the station
	localparam int PRF_SIZE     = 64;          // Physical registers
	localparam int ROB_SIZE     = 32;          // ROB slots
	localparam int WORD_W       = 64;          // Operand and CDB width
	localparam int OP_TYPE_W    = 6;
	localparam int ALU_FUNC_W   = 5;
	localparam int OP_GROUP_LSB = 3;           // Group sits in op_type[5:3]

	typedef logic [WORD_W-1:0]                 word_t;
	typedef logic [$clog2(PRF_SIZE)-1:0]       prf_tag_t;
	typedef logic [$clog2(ROB_SIZE)-1:0]       rob_idx_t;
	typedef logic [OP_TYPE_W-1:0]              op_type_t;
	typedef logic [OP_TYPE_W-OP_GROUP_LSB-1:0] op_group_t;
	typedef logic [ALU_FUNC_W-1:0]             alu_func_t;
	typedef logic [RS_SIZE-1:0]                rs_mask_t;  // One bit per entry
	typedef logic [1:0]                        fu_class_t;
	typedef logic [1:0]                        rs_space_t;

	// Functional-unit classes
	localparam fu_class_t FU_ADDER  = 2'd0;
	localparam fu_class_t FU_MULT   = 2'd1;
	localparam fu_class_t FU_MEMORY = 2'd2;

	// Occupancy levels reported to rename
	localparam rs_space_t RS_NO_ENTRY_EMPTY    = 2'd0;
	localparam rs_space_t RS_ONE_ENTRY_EMPTY   = 2'd1;
	localparam rs_space_t RS_TWO_OR_MORE_EMPTY = 2'd2;

	// ALU function codes
	localparam alu_func_t ALU_MULQ    = 5'h0b;  // 64-bit multiply
	localparam alu_func_t ALU_DEFAULT = 5'h1f;  // Shown on an idle issue port

	// Opcode groups, compared against op_type[5:3]
	localparam op_group_t OPG_MULT  = 3'd2;
	localparam op_group_t OPG_MEM_A = 3'd1;
	localparam op_group_t OPG_MEM_B = 3'd4;
	localparam op_group_t OPG_MEM_C = 3'd5;

	// One-hot of the lowest set bit, zero for an empty mask
	function automatic rs_mask_t lowest_set(input rs_mask_t mask);
		return mask & (~mask + 1'b1);
	endfunction

endpackage

// File: hw/rs_dispatch_decode.sv
/*
 * Dispatch front end of the reservation station
 *   FU class decode for both dispatch lanes
 *   Two-stage free-entry allocation, inst1 first
 *   Occupancy level for rename
 */
`timescale 1ns/1ps

module rs_dispatch_decode
	import rs_pkg::*;
(
	input  logic      clock,          // Samples the dispatch check only
	input  logic      arst_n,
	input  logic      inst1_load,
	input  logic      inst2_load,
	input  op_type_t  inst1_op_type,
	input  op_type_t  inst2_op_type,
	input  alu_func_t inst1_alu_func,
	input  alu_func_t inst2_alu_func,
	input  rs_mask_t  free_mask,      // From the entry bank
	output rs_mask_t  load1_mask,     // One-hot or zero
	output rs_mask_t  load2_mask,     // One-hot or zero
	output fu_class_t class1,
	output fu_class_t class2,
	output rs_space_t rs_space
);

	rs_mask_t second_pool;             // Free entries left over for inst2

	// Multiply needs both the group and MULQ, other group 2 ops go to the adder
	function automatic fu_class_t classify(input op_type_t op_type, input alu_func_t alu_func);
		op_group_t op_group;
		op_group = op_type[OP_TYPE_W-1:OP_GROUP_LSB];
		if (op_group == OPG_MULT && alu_func == ALU_MULQ)
			return FU_MULT;
		if (op_group == OPG_MEM_A || op_group == OPG_MEM_B || op_group == OPG_MEM_C)
			return FU_MEMORY;
		return FU_ADDER;
	endfunction

	assign class1 = classify(inst1_op_type, inst1_alu_func);
	assign class2 = classify(inst2_op_type, inst2_alu_func);

	// inst1 takes the lowest free entry, inst2 the lowest of what remains
	assign load1_mask  = inst1_load ? lowest_set(free_mask) : '0;
	assign second_pool = free_mask & ~load1_mask;
	assign load2_mask  = inst2_load ? lowest_set(second_pool) : '0;

	always_comb
	begin
		if (free_mask == '0)
			rs_space = RS_NO_ENTRY_EMPTY;
		else if ((free_mask & (free_mask - 1'b1)) == '0)   // Single bit left
			rs_space = RS_ONE_ENTRY_EMPTY;
		else
			rs_space = RS_TWO_OR_MORE_EMPTY;
	end

	// Rename must respect rs_space, so every raised load lands in an entry
	a_load_has_entry: assert property (@(posedge clock) disable iff (!arst_n)
		(!inst1_load || load1_mask != '0) && (!inst2_load || load2_mask != '0));

endmodule

// File: hw/rs_entry_bank.sv
/*
 * Entry storage of the reservation station
 *   Eight entries with busy bit, operands, valid flags, class and payload
 *   Load from either dispatch lane with same-cycle CDB bypass
 *   Operand wakeup from CDB1 and CDB2, CDB1 first
 *   Release of granted entries, free and ready masks
 */
`timescale 1ns/1ps

module rs_entry_bank
	import rs_pkg::*;
(
	input  logic                         clock,
	input  logic                         arst_n,
	input  rs_mask_t                     load1_mask,
	input  rs_mask_t                     load2_mask,
	input  fu_class_t                    class1,
	input  fu_class_t                    class2,
	input  word_t                        inst1_opa,
	input  word_t                        inst1_opb,
	input  logic                         inst1_opa_valid,   // Low: opa holds a tag
	input  logic                         inst1_opb_valid,
	input  prf_tag_t                     inst1_dest,
	input  rob_idx_t                     inst1_rob_idx,
	input  op_type_t                     inst1_op_type,
	input  alu_func_t                    inst1_alu_func,
	input  word_t                        inst2_opa,
	input  word_t                        inst2_opb,
	input  logic                         inst2_opa_valid,
	input  logic                         inst2_opb_valid,
	input  prf_tag_t                     inst2_dest,
	input  rob_idx_t                     inst2_rob_idx,
	input  op_type_t                     inst2_op_type,
	input  alu_func_t                    inst2_alu_func,
	input  logic                         cdb1_valid,
	input  prf_tag_t                     cdb1_tag,
	input  word_t                        cdb1_value,
	input  logic                         cdb2_valid,
	input  prf_tag_t                     cdb2_tag,
	input  word_t                        cdb2_value,
	input  rs_mask_t                     grant1_mask,
	input  rs_mask_t                     grant2_mask,
	output rs_mask_t                     free_mask,
	output rs_mask_t                     ready_mask,
	output fu_class_t [RS_SIZE-1:0]      entry_class,
	output word_t     [RS_SIZE-1:0]      entry_opa,
	output word_t     [RS_SIZE-1:0]      entry_opb,
	output prf_tag_t  [RS_SIZE-1:0]      entry_dest,
	output rob_idx_t  [RS_SIZE-1:0]      entry_rob_idx,
	output op_type_t  [RS_SIZE-1:0]      entry_op_type,
	output alu_func_t [RS_SIZE-1:0]      entry_alu_func
);

	// {valid, value} of an operand after watching both result buses
	function automatic logic [WORD_W:0] snoop(input word_t value, input logic valid);
		logic [WORD_W:0] result;
		result = {valid, value};
		if (!valid && cdb1_valid && cdb1_tag == prf_tag_t'(value))
			result = {1'b1, cdb1_value};          // CDB1 wins a double match
		else if (!valid && cdb2_valid && cdb2_tag == prf_tag_t'(value))
			result = {1'b1, cdb2_value};
		return result;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Entries
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < RS_SIZE; i++)
	begin : g_entry
		logic            busy;
		logic            opa_valid;
		logic            opb_valid;
		word_t           opa;
		word_t           opb;
		fu_class_t       fu_class;
		prf_tag_t        dest;
		rob_idx_t        rob_idx;
		op_type_t        op_type;
		alu_func_t       alu_func;
		logic [WORD_W:0] opa_next;         // {valid, value}
		logic [WORD_W:0] opb_next;

		// Source is the loading lane, otherwise the stored operand
		always_comb
		begin
			if (load1_mask[i])
			begin
				opa_next = snoop(inst1_opa, inst1_opa_valid);   // Same-cycle bypass
				opb_next = snoop(inst1_opb, inst1_opb_valid);
			end
			else if (load2_mask[i])
			begin
				opa_next = snoop(inst2_opa, inst2_opa_valid);
				opb_next = snoop(inst2_opb, inst2_opb_valid);
			end
			else
			begin
				opa_next = snoop(opa, opa_valid);
				opb_next = snoop(opb, opb_valid);
			end
		end

		always_ff @(posedge clock or negedge arst_n)
		begin
			if (!arst_n)
			begin
				busy      <= 1'b0;
				opa_valid <= 1'b0;
				opb_valid <= 1'b0;
			end
			else
			begin
				if (load1_mask[i] | load2_mask[i])
					busy <= 1'b1;
				else if (grant1_mask[i] | grant2_mask[i])
					busy <= 1'b0;             // Issued, free next cycle
				opa_valid <= opa_next[WORD_W];
				opb_valid <= opb_next[WORD_W];
			end
		end

		always_ff @(posedge clock)
		begin
			opa <= opa_next[WORD_W-1:0];
			opb <= opb_next[WORD_W-1:0];
			if (load1_mask[i])
			begin
				fu_class <= class1;
				dest     <= inst1_dest;
				rob_idx  <= inst1_rob_idx;
				op_type  <= inst1_op_type;
				alu_func <= inst1_alu_func;
			end
			else if (load2_mask[i])
			begin
				fu_class <= class2;
				dest     <= inst2_dest;
				rob_idx  <= inst2_rob_idx;
				op_type  <= inst2_op_type;
				alu_func <= inst2_alu_func;
			end
		end

		assign free_mask[i]      = ~busy;
		assign ready_mask[i]     = busy & opa_valid & opb_valid;
		assign entry_class[i]    = fu_class;
		assign entry_opa[i]      = opa;
		assign entry_opb[i]      = opb;
		assign entry_dest[i]     = dest;
		assign entry_rob_idx[i]  = rob_idx;
		assign entry_op_type[i]  = op_type;
		assign entry_alu_func[i] = alu_func;
	end

	//////////////////////////////////////////////////////////////////////
	// Checks on what the pickers hand in
	//////////////////////////////////////////////////////////////////////

	a_masks_onehot: assert property (@(posedge clock) disable iff (!arst_n)
		$onehot0(load1_mask) && $onehot0(load2_mask) &&
		$onehot0(grant1_mask) && $onehot0(grant2_mask));

	a_grant_ready: assert property (@(posedge clock) disable iff (!arst_n)
		((grant1_mask | grant2_mask) & ~ready_mask) == '0);

endmodule

// File: hw/rs_issue_select.sv
/*
 * Issue picker of the reservation station
 *   FU1 grant on the lowest ready entry
 *   FU2 grant with the single-unit class conflict rule
 *   Issue port muxing, idle ports show zeros and ALU_DEFAULT
 */
`timescale 1ns/1ps

module rs_issue_select
	import rs_pkg::*;
(
	input  logic                     clock,        // Samples the grant check only
	input  logic                     arst_n,
	input  rs_mask_t                 ready_mask,
	input  fu_class_t [RS_SIZE-1:0]  entry_class,
	input  word_t     [RS_SIZE-1:0]  entry_opa,
	input  word_t     [RS_SIZE-1:0]  entry_opb,
	input  prf_tag_t  [RS_SIZE-1:0]  entry_dest,
	input  rob_idx_t  [RS_SIZE-1:0]  entry_rob_idx,
	input  op_type_t  [RS_SIZE-1:0]  entry_op_type,
	input  alu_func_t [RS_SIZE-1:0]  entry_alu_func,
	input  logic                     fu1_mult_avail,
	input  logic                     fu1_adder_avail,
	input  logic                     fu1_mem_avail,
	input  logic                     fu2_mult_avail,
	input  logic                     fu2_adder_avail,
	input  logic                     fu2_mem_avail,
	output rs_mask_t                 grant1_mask,
	output rs_mask_t                 grant2_mask,
	output logic                     fu1_valid,
	output word_t                    fu1_opa,
	output word_t                    fu1_opb,
	output prf_tag_t                 fu1_dest_tag,
	output rob_idx_t                 fu1_rob_idx,
	output op_type_t                 fu1_op_type,
	output alu_func_t                fu1_alu_func,
	output logic                     fu2_valid,
	output word_t                    fu2_opa,
	output word_t                    fu2_opb,
	output prf_tag_t                 fu2_dest_tag,
	output rob_idx_t                 fu2_rob_idx,
	output op_type_t                 fu2_op_type,
	output alu_func_t                fu2_alu_func
);

	fu_class_t grant1_class;
	logic      class_conflict;       // Only one FU can take grant1's class
	rs_mask_t  candidates;           // FU2 choices

	assign grant1_mask = lowest_set(ready_mask);

	always_comb
	begin
		grant1_class = FU_ADDER;
		for (int i = 0; i < RS_SIZE; i++)
		begin
			if (grant1_mask[i])
				grant1_class = entry_class[i];
		end
	end

	always_comb
	begin
		case (grant1_class)
			FU_MULT:   class_conflict = fu1_mult_avail ^ fu2_mult_avail;
			FU_MEMORY: class_conflict = fu1_mem_avail ^ fu2_mem_avail;
			default:   class_conflict = fu1_adder_avail ^ fu2_adder_avail;
		endcase
	end

	// Drop grant1 and, on a conflict, every other entry of its class
	always_comb
	begin
		candidates = ready_mask & ~grant1_mask;
		for (int i = 0; i < RS_SIZE; i++)
		begin
			if (class_conflict && grant1_mask != '0 && entry_class[i] == grant1_class)
				candidates[i] = 1'b0;
		end
	end

	assign grant2_mask = lowest_set(candidates);

	//////////////////////////////////////////////////////////////////////
	// Issue ports
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		fu1_valid    = 1'b0;
		fu1_opa      = '0;
		fu1_opb      = '0;
		fu1_dest_tag = '0;
		fu1_rob_idx  = '0;
		fu1_op_type  = '0;
		fu1_alu_func = ALU_DEFAULT;
		fu2_valid    = 1'b0;
		fu2_opa      = '0;
		fu2_opb      = '0;
		fu2_dest_tag = '0;
		fu2_rob_idx  = '0;
		fu2_op_type  = '0;
		fu2_alu_func = ALU_DEFAULT;
		for (int i = 0; i < RS_SIZE; i++)
		begin
			if (grant1_mask[i])
			begin
				fu1_valid    = 1'b1;
				fu1_opa      = entry_opa[i];
				fu1_opb      = entry_opb[i];
				fu1_dest_tag = entry_dest[i];
				fu1_rob_idx  = entry_rob_idx[i];
				fu1_op_type  = entry_op_type[i];
				fu1_alu_func = entry_alu_func[i];
			end
			if (grant2_mask[i])
			begin
				fu2_valid    = 1'b1;
				fu2_opa      = entry_opa[i];
				fu2_opb      = entry_opb[i];
				fu2_dest_tag = entry_dest[i];
				fu2_rob_idx  = entry_rob_idx[i];
				fu2_op_type  = entry_op_type[i];
				fu2_alu_func = entry_alu_func[i];
			end
		end
	end

	// An entry never goes to both units in one cycle
	a_grants_disjoint: assert property (@(posedge clock) disable iff (!arst_n)
		(grant1_mask & grant2_mask) == '0);

endmodule

// File: hw/rs_top.sv
/*
 * Dual-dispatch, dual-issue reservation station
 *   Dispatch decode and allocation
 *   Entry bank with CDB wakeup
 *   Issue select for FU1 and FU2
 */
`timescale 1ns/1ps

module rs_top
	import rs_pkg::*;
(
	input  logic      clock,
	input  logic      arst_n,
	// Dispatch lane 1
	input  logic      inst1_load,
	input  word_t     inst1_opa,
	input  word_t     inst1_opb,
	input  logic      inst1_opa_valid,
	input  logic      inst1_opb_valid,
	input  prf_tag_t  inst1_dest,
	input  rob_idx_t  inst1_rob_idx,
	input  op_type_t  inst1_op_type,
	input  alu_func_t inst1_alu_func,
	// Dispatch lane 2
	input  logic      inst2_load,
	input  word_t     inst2_opa,
	input  word_t     inst2_opb,
	input  logic      inst2_opa_valid,
	input  logic      inst2_opb_valid,
	input  prf_tag_t  inst2_dest,
	input  rob_idx_t  inst2_rob_idx,
	input  op_type_t  inst2_op_type,
	input  alu_func_t inst2_alu_func,
	// Result buses, one-cycle strobes
	input  logic      cdb1_valid,
	input  prf_tag_t  cdb1_tag,
	input  word_t     cdb1_value,
	input  logic      cdb2_valid,
	input  prf_tag_t  cdb2_tag,
	input  word_t     cdb2_value,
	// Unit availability
	input  logic      fu1_mult_avail,
	input  logic      fu1_adder_avail,
	input  logic      fu1_mem_avail,
	input  logic      fu2_mult_avail,
	input  logic      fu2_adder_avail,
	input  logic      fu2_mem_avail,
	// Issue ports
	output logic      fu1_valid,
	output word_t     fu1_opa,
	output word_t     fu1_opb,
	output prf_tag_t  fu1_dest_tag,
	output rob_idx_t  fu1_rob_idx,
	output op_type_t  fu1_op_type,
	output alu_func_t fu1_alu_func,
	output logic      fu2_valid,
	output word_t     fu2_opa,
	output word_t     fu2_opb,
	output prf_tag_t  fu2_dest_tag,
	output rob_idx_t  fu2_rob_idx,
	output op_type_t  fu2_op_type,
	output alu_func_t fu2_alu_func,
	output rs_space_t rs_space         // Occupancy level to rename
);

	rs_mask_t                free_mask;
	rs_mask_t                ready_mask;
	rs_mask_t                load1_mask;
	rs_mask_t                load2_mask;
	rs_mask_t                grant1_mask;
	rs_mask_t                grant2_mask;
	fu_class_t               class1;
	fu_class_t               class2;
	fu_class_t [RS_SIZE-1:0] entry_class;
	word_t     [RS_SIZE-1:0] entry_opa;
	word_t     [RS_SIZE-1:0] entry_opb;
	prf_tag_t  [RS_SIZE-1:0] entry_dest;
	rob_idx_t  [RS_SIZE-1:0] entry_rob_idx;
	op_type_t  [RS_SIZE-1:0] entry_op_type;
	alu_func_t [RS_SIZE-1:0] entry_alu_func;

	// Port and wire names line up across the three blocks
	rs_dispatch_decode rs_dispatch_decode_i (.*);

	rs_entry_bank rs_entry_bank_i (.*);

	rs_issue_select rs_issue_select_i (.*);

endmodule

// File: tb/rs_tb.sv
/*
 * Testbench for the reservation station
 *   Clock, reset and DUT instance
 *   Stimulus reader, one line of inputs and expected outputs per cycle
 *   Compare tasks per result type
 *   Cycle timeout and final report
 */
`timescale 1ns/1ps

module rs_tb
	import rs_pkg::*;
();

	localparam int    CLK_PERIOD   = 100;
	localparam int    RESET_CYCLES = 5;
	localparam int    DRIVE_DELAY  = 1;                    // After the rising edge
	localparam int    SAMPLE_LEAD  = 10;                   // Before the next rising edge
	localparam int    SPARE_CYCLES = 20;
	localparam string STIM_FILE    = "tb/rs_stimulus.txt";

	// Clock and reset
	logic      clock;
	logic      arst_n;
	// Dispatch lane 1
	logic      inst1_load;
	word_t     inst1_opa;
	word_t     inst1_opb;
	logic      inst1_opa_valid;
	logic      inst1_opb_valid;
	prf_tag_t  inst1_dest;
	rob_idx_t  inst1_rob_idx;
	op_type_t  inst1_op_type;
	alu_func_t inst1_alu_func;
	// Dispatch lane 2
	logic      inst2_load;
	word_t     inst2_opa;
	word_t     inst2_opb;
	logic      inst2_opa_valid;
	logic      inst2_opb_valid;
	prf_tag_t  inst2_dest;
	rob_idx_t  inst2_rob_idx;
	op_type_t  inst2_op_type;
	alu_func_t inst2_alu_func;
	// Result buses
	logic      cdb1_valid;
	prf_tag_t  cdb1_tag;
	word_t     cdb1_value;
	logic      cdb2_valid;
	prf_tag_t  cdb2_tag;
	word_t     cdb2_value;
	// Unit availability
	logic      fu1_mult_avail;
	logic      fu1_adder_avail;
	logic      fu1_mem_avail;
	logic      fu2_mult_avail;
	logic      fu2_adder_avail;
	logic      fu2_mem_avail;
	// Issue ports and occupancy
	logic      fu1_valid;
	word_t     fu1_opa;
	word_t     fu1_opb;
	prf_tag_t  fu1_dest_tag;
	rob_idx_t  fu1_rob_idx;
	op_type_t  fu1_op_type;
	alu_func_t fu1_alu_func;
	logic      fu2_valid;
	word_t     fu2_opa;
	word_t     fu2_opb;
	prf_tag_t  fu2_dest_tag;
	rob_idx_t  fu2_rob_idx;
	op_type_t  fu2_op_type;
	alu_func_t fu2_alu_func;
	rs_space_t rs_space;

	// Expected outputs of the current stimulus line
	logic      exp_fu1_valid;
	prf_tag_t  exp_fu1_dest;
	word_t     exp_fu1_opa;
	word_t     exp_fu1_opb;
	rob_idx_t  exp_fu1_rob;
	logic      exp_fu2_valid;
	prf_tag_t  exp_fu2_dest;
	word_t     exp_fu2_opa;
	word_t     exp_fu2_opb;
	rob_idx_t  exp_fu2_rob;
	rs_space_t exp_space;

	// Op type and ALU function of each dispatched instruction per ROB slot
	op_type_t  dispatched_op [ROB_SIZE];
	alu_func_t dispatched_func [ROB_SIZE];

	string     test_name;                                  // Word from the line plus line number
	int        line_no;
	int        cycle_count = 0;
	int        cycle_limit;

	rs_top rs_top_i (.*);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// Run length guard with its limit set from the stimulus length
	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
			report_failure($sformatf("Timeout after %0d cycles, stimulus did not finish",
				cycle_count));
	end

	//////////////////////////////////////////////////////////////////////
	// Reporting and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "Stopped at the first failure");
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch in %s: expected %b, actual %b",
				name, expected, actual));
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch in %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic check_tag(input string name, input prf_tag_t expected,
		input prf_tag_t actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch in %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic check_rob(input string name, input rob_idx_t expected,
		input rob_idx_t actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch in %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic check_op(input string name, input op_type_t expected,
		input op_type_t actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch in %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic check_func(input string name, input alu_func_t expected,
		input alu_func_t actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch in %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic check_space(input string name, input rs_space_t expected,
		input rs_space_t actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch in %s: expected %0d, actual %0d",
				name, expected, actual));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus file handling
	//////////////////////////////////////////////////////////////////////

	// Comment lines start with # and blank lines are skipped
	function automatic bit is_data_line(input string text);
		return text.len() > 1 && text.getc(0) != "#";
	endfunction

	function automatic int count_data_lines();
		int    fd;
		int    count;
		string text;
		count = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd != 0)
		begin
			while ($fgets(text, fd) != 0)
			begin
				if (is_data_line(text))
					count++;
			end
			$fclose(fd);
		end
		return count;
	endfunction

	task automatic clear_inputs();
		inst1_load      = 1'b0;
		inst1_opa       = '0;
		inst1_opb       = '0;
		inst1_opa_valid = 1'b0;
		inst1_opb_valid = 1'b0;
		inst1_dest      = '0;
		inst1_rob_idx   = '0;
		inst1_op_type   = '0;
		inst1_alu_func  = '0;
		inst2_load      = 1'b0;
		inst2_opa       = '0;
		inst2_opb       = '0;
		inst2_opa_valid = 1'b0;
		inst2_opb_valid = 1'b0;
		inst2_dest      = '0;
		inst2_rob_idx   = '0;
		inst2_op_type   = '0;
		inst2_alu_func  = '0;
		cdb1_valid      = 1'b0;
		cdb1_tag        = '0;
		cdb1_value      = '0;
		cdb2_valid      = 1'b0;
		cdb2_tag        = '0;
		cdb2_value      = '0;
		{fu1_mult_avail, fu1_adder_avail, fu1_mem_avail} = 3'b000;
		{fu2_mult_avail, fu2_adder_avail, fu2_mem_avail} = 3'b000;
	endtask

	// Parses one line straight onto the DUT inputs and the expected values
	task automatic apply_line(input string text);
		string      word;
		logic [2:0] ctl1;                                  // {load, opa_valid, opb_valid}
		logic [2:0] ctl2;
		logic [5:0] avail;                                 // FU1 mul/add/mem, then FU2
		int         fields;
		fields = $sscanf(text,
			"%s%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
			word,
			ctl1, inst1_op_type, inst1_alu_func, inst1_dest, inst1_rob_idx,
			inst1_opa, inst1_opb,
			ctl2, inst2_op_type, inst2_alu_func, inst2_dest, inst2_rob_idx,
			inst2_opa, inst2_opb,
			cdb1_valid, cdb1_tag, cdb1_value, cdb2_valid, cdb2_tag, cdb2_value,
			avail,
			exp_fu1_valid, exp_fu1_dest, exp_fu1_opa, exp_fu1_opb, exp_fu1_rob,
			exp_fu2_valid, exp_fu2_dest, exp_fu2_opa, exp_fu2_opb, exp_fu2_rob,
			exp_space);
		if (fields != 33)
			report_failure($sformatf("Stimulus line %0d has %0d fields instead of 33",
				line_no, fields));
		inst1_load      = ctl1[2];
		inst1_opa_valid = ctl1[1];
		inst1_opb_valid = ctl1[0];
		inst2_load      = ctl2[2];
		inst2_opa_valid = ctl2[1];
		inst2_opb_valid = ctl2[0];
		{fu1_mult_avail, fu1_adder_avail, fu1_mem_avail,
			fu2_mult_avail, fu2_adder_avail, fu2_mem_avail} = avail;
		if (inst1_load)
		begin
			dispatched_op[inst1_rob_idx]   = inst1_op_type;
			dispatched_func[inst1_rob_idx] = inst1_alu_func;
		end
		if (inst2_load)
		begin
			dispatched_op[inst2_rob_idx]   = inst2_op_type;
			dispatched_func[inst2_rob_idx] = inst2_alu_func;
		end
		test_name = $sformatf("%s line %0d", word, line_no);
	endtask

	// Op type and ALU function follow the instruction named by the expected rob_idx
	task automatic compare_payload(input string port, input logic exp_valid,
		input rob_idx_t exp_rob, input op_type_t op_type, input alu_func_t alu_func);
		op_type_t  exp_op;
		alu_func_t exp_func;
		exp_op   = '0;                                     // Idle port
		exp_func = ALU_DEFAULT;
		if (exp_valid)
		begin
			exp_op   = dispatched_op[exp_rob];
			exp_func = dispatched_func[exp_rob];
		end
		check_op({test_name, " ", port, "_op_type"}, exp_op, op_type);
		check_func({test_name, " ", port, "_alu_func"}, exp_func, alu_func);
	endtask

	task automatic compare_outputs();
		check_bit({test_name, " fu1_valid"}, exp_fu1_valid, fu1_valid);
		check_tag({test_name, " fu1_dest_tag"}, exp_fu1_dest, fu1_dest_tag);
		check_word({test_name, " fu1_opa"}, exp_fu1_opa, fu1_opa);
		check_word({test_name, " fu1_opb"}, exp_fu1_opb, fu1_opb);
		check_rob({test_name, " fu1_rob_idx"}, exp_fu1_rob, fu1_rob_idx);
		compare_payload("fu1", exp_fu1_valid, exp_fu1_rob, fu1_op_type, fu1_alu_func);
		check_bit({test_name, " fu2_valid"}, exp_fu2_valid, fu2_valid);
		check_tag({test_name, " fu2_dest_tag"}, exp_fu2_dest, fu2_dest_tag);
		check_word({test_name, " fu2_opa"}, exp_fu2_opa, fu2_opa);
		check_word({test_name, " fu2_opb"}, exp_fu2_opb, fu2_opb);
		check_rob({test_name, " fu2_rob_idx"}, exp_fu2_rob, fu2_rob_idx);
		compare_payload("fu2", exp_fu2_valid, exp_fu2_rob, fu2_op_type, fu2_alu_func);
		check_space({test_name, " rs_space"}, exp_space, rs_space);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int    fd;
		string text;
		line_no  = 0;
		clock    = 1'b0;
		arst_n   = 1'b0;
		clear_inputs();
		cycle_limit = count_data_lines() + RESET_CYCLES + SPARE_CYCLES;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
			report_failure({"Cannot open the stimulus file ", STIM_FILE});
		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY;
		arst_n = 1'b1;                                     // First line drives in this cycle
		while ($fgets(text, fd) != 0)
		begin
			line_no++;
			if (is_data_line(text))
			begin
				apply_line(text);
				#(CLK_PERIOD - DRIVE_DELAY - SAMPLE_LEAD);   // Outputs settled here
				compare_outputs();
				@(posedge clock);
				#DRIVE_DELAY;
			end
		end
		$fclose(fd);
		$display("All tests passed");
		$finish;
	end

endmodule

// File: tb/rs_stimulus.txt
# name, lane1 then lane2 {ctl op_type alu_func dest rob opa opb}, ctl = {load opa_v opb_v}
# cdb1 then cdb2 {valid tag value}, avail {fu1 mul add mem, fu2 mul add mem}
# expected fu1 then fu2 {valid dest opa opb rob}, rs_space (0 none, 1 one, 2 two or more)
rst  0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 0 00 00 00 00 0 00 00 00 00 2
dual 7 18 00 01 01 11 12 7 18 00 02 02 21 22 0 00 00 0 00 00 3f 0 00 00 00 00 0 00 00 00 00 2
dual 0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 1 01 11 12 01 1 02 21 22 02 2
wake 6 18 00 03 03 31 05 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 0 00 00 00 00 0 00 00 00 00 2
wake 0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 0 00 00 00 00 0 00 00 00 00 2
wake 0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 1 05 55 3f 0 00 00 00 00 0 00 00 00 00 2
wake 0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 1 03 31 55 03 0 00 00 00 00 2
byp  6 18 00 04 04 41 07 0 00 00 00 00 00 00 1 07 77 0 00 00 3f 0 00 00 00 00 0 00 00 00 00 2
byp  0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 1 04 41 77 04 0 00 00 00 00 2
conf 7 10 0b 05 05 51 52 7 10 0b 06 06 61 62 0 00 00 0 00 00 3b 0 00 00 00 00 0 00 00 00 00 2
conf 7 10 0b 07 07 71 72 0 00 00 00 00 00 00 0 00 00 0 00 00 3b 1 05 51 52 05 0 00 00 00 00 2
conf 0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 1 06 61 62 06 1 07 71 72 07 2
conf 7 10 0b 08 08 81 82 7 18 00 09 09 91 92 0 00 00 0 00 00 3b 0 00 00 00 00 0 00 00 00 00 2
conf 0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3b 1 08 81 82 08 1 09 91 92 09 2
cls  7 10 0b 0a 0a a1 a2 7 10 01 0b 0b b1 b2 0 00 00 0 00 00 3b 0 00 00 00 00 0 00 00 00 00 2
cls  0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3b 1 0a a1 a2 0a 1 0b b1 b2 0b 2
occ  6 18 00 10 10 c1 20 6 18 00 11 11 c2 20 0 00 00 0 00 00 3f 0 00 00 00 00 0 00 00 00 00 2
occ  6 18 00 12 12 c3 20 6 18 00 13 13 c4 20 0 00 00 0 00 00 3f 0 00 00 00 00 0 00 00 00 00 2
occ  6 18 00 14 14 c5 20 6 18 00 15 15 c6 20 0 00 00 0 00 00 3f 0 00 00 00 00 0 00 00 00 00 2
occ  6 18 00 16 16 c7 20 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 0 00 00 00 00 0 00 00 00 00 2
occ  6 18 00 17 17 c8 20 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 0 00 00 00 00 0 00 00 00 00 1
occ  0 00 00 00 00 00 00 0 00 00 00 00 00 00 1 20 99 0 00 00 3f 0 00 00 00 00 0 00 00 00 00 0
occ  0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3d 1 10 c1 99 10 0 00 00 00 00 0
occ  0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 1 11 c2 99 11 1 12 c3 99 12 1
occ  0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 1 13 c4 99 13 1 14 c5 99 14 2
occ  0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 1 15 c6 99 15 1 16 c7 99 16 2
occ  0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 1 17 c8 99 17 0 00 00 00 00 2
occ  0 00 00 00 00 00 00 0 00 00 00 00 00 00 0 00 00 0 00 00 3f 0 00 00 00 00 0 00 00 00 00 2

// File: all.f
hw/rs_pkg.sv
hw/rs_dispatch_decode.sv
hw/rs_entry_bank.sv
hw/rs_issue_select.sv
hw/rs_top.sv
tb/rs_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the reservation station testbench with Verilator and runs it.
# The run counts as passed only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module rs_tb -Mdir "$BUILD_DIR" -f all.f; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vrs_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ "$run_status" -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
	echo "Result: pass"
	exit 0
fi

echo "Result: fail"
exit 1
